// File: Bender.yml
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_fetch.sv
  - hdl/rv_decode.sv
  - hdl/rv_regfile.sv
  - hdl/rv_execute.sv
  - hdl/rv_lsu.sv
  - hdl/rv_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_rv_core.sv

// File: compile.f
+incdir+include
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
test/tb_rv_core.sv

// File: hdl/rv_core.sv
`timescale 1ns/10ps

module rv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic     clk,
  input  logic     rst_n,
  output logic     imem_ren,
  output word_t    imem_raddr,
  input  word_t    imem_rdata,
  output logic     dmem_ren,
  output word_t    dmem_raddr,
  input  word_t    dmem_rdata,
  output dmem_wr_t dmem_wr,
  output logic     ebreak,
  output logic     trap
);

  word_t pc;
  ctrl_t ctrl;
  word_t imm;
  logic  is_ebreak;
  logic  illegal;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  logic  branch_taken;
  word_t target;
  word_t load_data;
  word_t rd_data;
  logic  halt;
  logic  enable;

  assign halt = ebreak || trap;

  // Retire only out of reset, not halted and not halting now
  assign enable = rst_n && !halt && !is_ebreak && !illegal;

  assign imem_ren   = rst_n && !halt;
  assign imem_raddr = pc;

  // ------------------------------
  // Stages
  // ------------------------------
  rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_taken   (branch_taken),
    .is_jump        (ctrl.is_jump),
    .target         (target),
    .halt_req_ebreak(is_ebreak),
    .halt_req_trap  (illegal),
    .pc             (pc),
    .ebreak         (ebreak),
    .trap           (trap)
  );

  rv_decode u_decode (
    .instr    (imem_rdata),
    .ctrl     (ctrl),
    .imm      (imm),
    .is_ebreak(is_ebreak),
    .illegal  (illegal)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rs1     (ctrl.rs1),
    .rs2     (ctrl.rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we      (enable && ctrl.reg_write),
    .rd      (ctrl.rd),
    .rd_data (rd_data)
  );

  rv_execute u_execute (
    .ctrl        (ctrl),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .alu_result  (alu_result),
    .branch_taken(branch_taken),
    .target      (target)
  );

  // Address comes from the ALU adder, store data from rs2
  rv_lsu u_lsu (
    .ctrl      (ctrl),
    .addr      (alu_result),
    .store_data(rs2_data),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_wr   (dmem_wr),
    .load_data (load_data),
    .enable    (enable)
  );

  // ------------------------------
  // Write-back select
  // ------------------------------
  always_comb begin
    case (ctrl.res_src)
      RES_MEM: rd_data = load_data;
      RES_PC4: rd_data = pc + word_t'(4);
      default: rd_data = alu_result;
    endcase
  end

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/10ps

module rv_decode import rv_pkg::*; (
  input  word_t instr,
  output ctrl_t ctrl,
  output word_t imm,
  output logic  is_ebreak,
  output logic  illegal
);

  localparam word_t EBREAK_INSTR = 32'h0010_0073;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // Shared funct3 to ALU op map for OP and OP-IMM
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // ------------------------------
  // Immediate formats
  // ------------------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ------------------------------
  // Control generation
  // ------------------------------
  always_comb begin
    ctrl               = '0;
    ctrl.alu_op        = ALU_ADD;
    ctrl.res_src       = RES_ALU;
    ctrl.mem_size      = SIZE_W;
    ctrl.branch_funct3 = funct3;
    ctrl.rd            = instr[11:7];
    ctrl.rs1           = instr[19:15];
    ctrl.rs2           = instr[24:20];
    imm                = imm_i;
    is_ebreak          = 1'b0;
    illegal            = 1'b0;

    case (opcode)
      OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.alu_b_imm = 1'b1;
        imm            = imm_u;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        // Only SRAI may set funct7[5]; ADDI has no subtract form
        ctrl.alu_op    = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      OP_REG: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_from_funct3(funct3, funct7[5]);
        // Alternate encoding only exists for SUB and SRA
        if (funct7 == 7'b0100000) begin
          illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          illegal = (funct7 != 7'b0000000);
        end
      end
      OP_LOAD: begin
        ctrl.reg_write    = 1'b1;
        ctrl.alu_b_imm    = 1'b1;
        ctrl.res_src      = RES_MEM;
        ctrl.mem_read     = 1'b1;
        ctrl.mem_size     = mem_size_e'(funct3[1:0]);
        ctrl.mem_unsigned = funct3[2];
        // LB LH LW LBU LHU only
        illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OP_STORE: begin
        ctrl.alu_b_imm = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.mem_size  = mem_size_e'(funct3[1:0]);
        imm            = imm_s;
        illegal        = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
        // funct3 010 and 011 are unused
        illegal        = (funct3[2:1] == 2'b01);
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.res_src   = RES_PC4;
        ctrl.is_jump   = 1'b1;
        imm            = imm_j;
      end
      OP_SYSTEM: begin
        is_ebreak = (instr == EBREAK_INSTR);
        illegal   = !is_ebreak;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    // An invalid instruction has no side effects
    if (illegal) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.is_branch = 1'b0;
      ctrl.is_jump   = 1'b0;
    end
  end

endmodule

// File: hdl/rv_execute.sv
`timescale 1ns/10ps

module rv_execute import rv_pkg::*; (
  input  ctrl_t ctrl,
  input  word_t pc,
  input  word_t rs1_data,
  input  word_t rs2_data,
  input  word_t imm,
  output word_t alu_result,
  output logic  branch_taken,
  output word_t target
);

  word_t      alu_b;
  logic [4:0] shamt;
  logic       cond;

  // ------------------------------
  // ALU
  // ------------------------------
  assign alu_b = ctrl.alu_b_imm ? imm : rs2_data;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    alu_result = rs1_data + alu_b;
      ALU_SUB:    alu_result = rs1_data - alu_b;
      ALU_SLL:    alu_result = rs1_data << shamt;
      ALU_SLT:    alu_result = word_t'($signed(rs1_data) < $signed(alu_b));
      ALU_SLTU:   alu_result = word_t'(rs1_data < alu_b);
      ALU_XOR:    alu_result = rs1_data ^ alu_b;
      ALU_SRL:    alu_result = rs1_data >> shamt;
      ALU_SRA:    alu_result = word_t'($signed(rs1_data) >>> shamt);
      ALU_OR:     alu_result = rs1_data | alu_b;
      ALU_AND:    alu_result = rs1_data & alu_b;
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // ------------------------------
  // Branch compare
  // ------------------------------
  // Always on the two registers, independent of alu_b
  always_comb begin
    case (ctrl.branch_funct3)
      3'b000:  cond = (rs1_data == rs2_data);
      3'b001:  cond = (rs1_data != rs2_data);
      3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  cond = (rs1_data < rs2_data);
      3'b111:  cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = ctrl.is_branch && cond;

  // PC relative target, shared by branches and JAL
  assign target = pc + imm;

endmodule

// File: hdl/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  branch_taken,
  input  logic  is_jump,
  input  word_t target,
  input  logic  halt_req_ebreak,
  input  logic  halt_req_trap,
  output word_t pc,
  output logic  ebreak,
  output logic  trap
);

  logic  halt;
  word_t pc_next;

  assign halt = ebreak || trap;

  // Redirect on taken branch or JAL, else fall through
  assign pc_next = (branch_taken || is_jump) ? target : pc + word_t'(4);

  // ------------------------------
  // PC and sticky halt
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= RESET_PC;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else if (!halt) begin
      if (halt_req_ebreak) begin
        ebreak <= 1'b1;
      end
      if (halt_req_trap) begin
        trap <= 1'b1;
      end
      // PC stays on the halting instruction
      if (!(halt_req_ebreak || halt_req_trap)) begin
        pc <= pc_next;
      end
    end
  end

endmodule

// File: hdl/rv_lsu.sv
`timescale 1ns/10ps

module rv_lsu import rv_pkg::*; (
  input  ctrl_t    ctrl,
  input  word_t    addr,
  input  word_t    store_data,
  output logic     dmem_ren,
  output word_t    dmem_raddr,
  input  word_t    dmem_rdata,
  output dmem_wr_t dmem_wr,
  output word_t    load_data,
  input  logic     enable
);

  word_t rdata_shifted;

  // ------------------------------
  // Store path
  // ------------------------------
  always_comb begin
    dmem_wr.we   = enable && ctrl.mem_write;
    dmem_wr.addr = addr;
    case (ctrl.mem_size)
      SIZE_B: begin
        // Byte copied to all four lanes
        dmem_wr.data = {4{store_data[7:0]}};
        dmem_wr.strb = 4'b0001 << addr[1:0];
      end
      SIZE_H: begin
        dmem_wr.data = {2{store_data[15:0]}};
        dmem_wr.strb = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wr.data = store_data;
        dmem_wr.strb = 4'b1111;
      end
    endcase
  end

  // ------------------------------
  // Load path
  // ------------------------------
  assign dmem_ren   = enable && ctrl.mem_read;
  assign dmem_raddr = addr;

  // Addressed lane moved down to bit 0
  assign rdata_shifted = dmem_rdata >> {addr[1:0], 3'b000};

  always_comb begin
    case (ctrl.mem_size)
      SIZE_B: begin
        load_data = ctrl.mem_unsigned ? {24'b0, rdata_shifted[7:0]}
                                      : {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      end
      SIZE_H: begin
        load_data = ctrl.mem_unsigned ? {16'b0, rdata_shifted[15:0]}
                                      : {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
      end
      default: begin
        load_data = dmem_rdata;
      end
    endcase
  end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int XLEN = 32;
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // ------------------------------
  // Encodings
  // ------------------------------

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } res_src_e;

  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W
  } mem_size_e;

  // ------------------------------
  // Structs
  // ------------------------------

  // Decoded control of one instruction
  typedef struct packed {
    logic       reg_write;
    alu_op_e    alu_op;
    logic       alu_b_imm;
    res_src_e   res_src;
    logic       mem_read;
    logic       mem_write;
    mem_size_e  mem_size;
    logic       mem_unsigned;
    logic       is_branch;
    logic       is_jump;
    logic [2:0] branch_funct3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
  } ctrl_t;

  // Data memory write port
  typedef struct packed {
    logic       we;
    word_t      addr;
    word_t      data;
    logic [3:0] strb;
  } dmem_wr_t;

endpackage

// File: hdl/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    rd_data
);

  // x0 slot exists but is never written
  word_t regs [1 << REG_AW];

  // Synchronous write port
  always_ff @(posedge clk) begin
    if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // Asynchronous reads, x0 forced to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: include/tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// ------------------------------
// Reference ISA model state
// ------------------------------
localparam word_t EBREAK_WORD = 32'h0010_0073;

word_t    m_regs [32];
word_t    m_mem [512];
word_t    m_pc;
logic     m_halted;
logic     m_trap;

// Port activity expected for the instruction at m_pc
dmem_wr_t exp_wr;
logic     exp_ren;
word_t    exp_raddr;

// RV32I integer ops, alt selects SUB or SRA
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return $signed(a) < $signed(b);
    3'b011:  return a < b;
    3'b100:  return a ^ b;
    3'b101: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// Pick the addressed lane, then extend per funct3
function automatic word_t load_ref(input word_t w, input logic [1:0] lane,
                                   input logic [2:0] f3);
  logic [7:0]  bt;
  logic [15:0] hw;
  bt = w[8*lane +: 8];
  hw = lane[1] ? w[31:16] : w[15:0];
  case (f3)
    3'b000:  return {{24{bt[7]}}, bt};
    3'b001:  return {{16{hw[15]}}, hw};
    3'b100:  return {24'b0, bt};
    3'b101:  return {16'b0, hw};
    default: return w;
  endcase
endfunction

// Execute one instruction, fill exp_* and commit model state
task automatic model_step(input word_t instr);
  logic [2:0] f3;
  reg_idx_t   rd;
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      imm_s;
  word_t      addr;
  word_t      res;
  word_t      next_pc;
  logic       wr_rd;
  logic       taken;
  f3        = instr[14:12];
  rd        = instr[11:7];
  a         = m_regs[instr[19:15]];
  b         = m_regs[instr[24:20]];
  imm_i     = {{20{instr[31]}}, instr[31:20]};
  imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  res       = '0;
  wr_rd     = 1'b0;
  taken     = 1'b0;
  next_pc   = m_pc + 32'd4;
  exp_wr    = '0;
  exp_ren   = 1'b0;
  exp_raddr = '0;
  case (instr[6:0])
    7'b0110111: begin
      res   = {instr[31:12], 12'b0};
      wr_rd = 1'b1;
    end
    7'b0010011: begin
      // Only SRAI uses instr[30] as a selector
      res   = alu_ref(f3, (f3 == 3'b101) && instr[30], a, imm_i);
      wr_rd = 1'b1;
    end
    7'b0110011: begin
      res   = alu_ref(f3, instr[30], a, b);
      wr_rd = 1'b1;
    end
    7'b0000011: begin
      addr      = a + imm_i;
      exp_ren   = 1'b1;
      exp_raddr = addr;
      res       = load_ref(m_mem[addr[10:2]], addr[1:0], f3);
      wr_rd     = 1'b1;
    end
    7'b0100011: begin
      addr        = a + imm_s;
      exp_wr.we   = 1'b1;
      exp_wr.addr = addr;
      // Narrow stores show the value in every lane
      case (f3)
        3'b000: begin
          exp_wr.data = {4{b[7:0]}};
          exp_wr.strb = 4'b0001 << addr[1:0];
        end
        3'b001: begin
          exp_wr.data = {2{b[15:0]}};
          exp_wr.strb = 4'b0011 << addr[1:0];
        end
        default: begin
          exp_wr.data = b;
          exp_wr.strb = 4'b1111;
        end
      endcase
      for (int i = 0; i < 4; i++) begin
        if (exp_wr.strb[i]) begin
          m_mem[addr[10:2]][8*i +: 8] = exp_wr.data[8*i +: 8];
        end
      end
    end
    7'b1100011: begin
      case (f3)
        3'b000:  taken = (a == b);
        3'b001:  taken = (a != b);
        3'b100:  taken = ($signed(a) < $signed(b));
        3'b101:  taken = ($signed(a) >= $signed(b));
        3'b110:  taken = (a < b);
        default: taken = (a >= b);
      endcase
      if (taken) begin
        next_pc = m_pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
      end
    end
    7'b1101111: begin
      res     = m_pc + 32'd4;
      wr_rd   = 1'b1;
      next_pc = m_pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                        instr[30:21], 1'b0};
    end
    default: begin
      // EBREAK or an unknown opcode, PC stays put
      m_halted = 1'b1;
      m_trap   = (instr != EBREAK_WORD);
      next_pc  = m_pc;
    end
  endcase
  if (wr_rd && (rd != 5'd0)) begin
    m_regs[rd] = res;
  end
  m_pc = next_pc;
endtask

// ------------------------------
// Program generator
// ------------------------------

// Either LUI rd or ADDI rd, x0, imm
function automatic word_t init_instr(input reg_idx_t rd);
  word_t r;
  r = lfsr_bits(21);
  if (r[20]) begin
    return {r[19:0], rd, 7'b0110111};
  end
  return {r[11:0], 5'd0, 3'b000, rd, 7'b0010011};
endfunction

// SW rs2, ofs(x0)
function automatic word_t enc_sw(input reg_idx_t rs2, input logic [11:0] ofs);
  return {ofs[11:5], rs2, 5'd0, 3'b010, ofs[4:0], 7'b0100011};
endfunction

// Random instruction of the kept set; words_left of 0 means no branch or JAL
function automatic word_t random_instr(input int words_left);
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  logic [2:0]  f3;
  logic [2:0]  kind;
  logic [6:0]  f7;
  logic [11:0] imm;
  logic [20:0] off;
  int          k;
  rd   = reg_idx_t'(lfsr_bits(5));
  rs1  = reg_idx_t'(lfsr_bits(5));
  rs2  = reg_idx_t'(lfsr_bits(5));
  f3   = 3'(lfsr_bits(3));
  imm  = 12'(lfsr_bits(12));
  kind = 3'(lfsr_bits(3));
  if ((words_left == 0) && (kind >= 3'd6)) begin
    kind = 3'd5;
  end
  // Forward by 1 to 4 words, never past the last word
  k = 1 + int'(lfsr_bits(2));
  if (k > words_left) begin
    k = words_left;
  end
  off = 21'(k * 4);
  case (kind)
    3'd0: return {imm, rs1, f3, rd, 7'b0110111};
    3'd1, 3'd2: begin
      if (f3 == 3'b001) begin
        imm[11:5] = 7'b0;
      end
      if (f3 == 3'b101) begin
        imm[11:5] = {1'b0, imm[10], 5'b0};
      end
      return {imm, rs1, f3, rd, 7'b0010011};
    end
    3'd3: begin
      f7 = ((f3 == 3'b000) || (f3 == 3'b101)) ? {1'b0, imm[0], 5'b0} : 7'b0;
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
    end
    3'd4: begin
      // LB LH LW LBU LHU, base x0, aligned offset
      if (f3[1:0] == 2'b11) begin
        f3[1:0] = 2'b10;
      end
      if (f3 == 3'b110) begin
        f3 = 3'b100;
      end
      imm[11] = 1'b0;
      if (f3[0]) begin
        imm[0] = 1'b0;
      end
      if (f3[1]) begin
        imm[1:0] = 2'b00;
      end
      return {imm, 5'd0, f3, rd, 7'b0000011};
    end
    3'd5: begin
      f3[2] = 1'b0;
      if (f3[1:0] == 2'b11) begin
        f3[1:0] = 2'b10;
      end
      imm[11] = 1'b0;
      if (f3[0]) begin
        imm[0] = 1'b0;
      end
      if (f3[1]) begin
        imm[1:0] = 2'b00;
      end
      return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
    end
    3'd6: begin
      // funct3 010 and 011 folded onto LTU and GEU
      if (f3[2:1] == 2'b01) begin
        f3[2] = 1'b1;
      end
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    end
    default: return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endcase
endfunction

`endif

// File: test/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core import rv_pkg::*; ();

  localparam int PROG_WORDS     = 200;
  // Two programs with reset and halt margins
  localparam int TIMEOUT_CYCLES = 2 * (256 + 20);

  logic     clk;
  logic     rst_n;
  logic     imem_ren;
  word_t    imem_raddr;
  word_t    imem_rdata;
  logic     dmem_ren;
  word_t    dmem_raddr;
  word_t    dmem_rdata;
  dmem_wr_t dmem_wr;
  logic     ebreak;
  logic     trap;

  word_t    imem [256];
  word_t    dmem [512];
  word_t    lfsr_state = 32'h4eb4_cfda;
  int       cycle_count = 0;

  // ------------------------------
  // Random source
  // ------------------------------

  // Galois LFSR stepped once per returned bit
  function automatic word_t lfsr_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  `include "tb_rv_model.svh"

  rv_core #(.RESET_PC(32'h0)) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_ren  (imem_ren),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_wr   (dmem_wr),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // Memories
  // ------------------------------

  // Zero-latency reads
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_raddr[10:2]];

  always @(posedge clk) begin
    if (dmem_wr.we) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_wr.strb[i]) begin
          dmem[dmem_wr.addr[10:2]][8*i +: 8] <= dmem_wr.data[8*i +: 8];
        end
      end
    end
  end

  // Run length guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic abort_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t act, input word_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_wr(input string name, input dmem_wr_t act, input dmem_wr_t exp);
    logic bad;
    // Address, data and strobe only count while a write is expected
    bad = exp.we ? (act !== exp) : (act.we !== 1'b0);
    if (bad) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, act, exp);
      abort_run();
    end
  endtask

  // Eight low cycles with idle outputs checked before release
  task automatic reset_dut();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_word("imem_raddr", imem_raddr, '0);
    check_bit("ebreak", ebreak, 1'b0);
    check_bit("trap", trap, 1'b0);
    check_bit("dmem_wr.we", dmem_wr.we, 1'b0);
    check_bit("dmem_ren", dmem_ren, 1'b0);
    @(posedge clk);
    rst_n <= 1'b1;
    m_pc     = '0;
    m_halted = 1'b0;
    m_trap   = 1'b0;
  endtask

  // One instruction per cycle compared mid-cycle against the model
  task automatic run_until_halt();
    while (!m_halted) begin
      @(negedge clk);
      check_bit("imem_ren", imem_ren, 1'b1);
      check_word("imem_raddr", imem_raddr, m_pc);
      check_bit("ebreak", ebreak, 1'b0);
      check_bit("trap", trap, 1'b0);
      model_step(imem[m_pc[9:2]]);
      check_wr("dmem_wr", dmem_wr, exp_wr);
      check_bit("dmem_ren", dmem_ren, exp_ren);
      if (exp_ren) begin
        check_word("dmem_raddr", dmem_raddr, exp_raddr);
      end
    end
  endtask

  // Frozen fetch and quiet memory ports after the halt
  task automatic watch_halt(input word_t halt_pc);
    repeat (10) begin
      @(negedge clk);
      check_bit("ebreak", ebreak, !m_trap);
      check_bit("trap", trap, m_trap);
      check_word("imem_raddr", imem_raddr, halt_pc);
      check_bit("imem_ren", imem_ren, 1'b0);
      check_bit("dmem_ren", dmem_ren, 1'b0);
      check_bit("dmem_wr.we", dmem_wr.we, 1'b0);
    end
  endtask

  task automatic compare_memory();
    for (int i = 0; i < 512; i++) begin
      check_word($sformatf("dmem[%0d]", i), dmem[i], m_mem[i]);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    word_t bad_word;
    rst_n = 1'b0;
    for (int i = 0; i < 512; i++) begin
      dmem[i]  = (word_t'(i) * 32'h9e37_79b9) ^ (word_t'(i) << 2);
      m_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end

    // Program 1 loads x1, gives x2 to x31 a value, then random code, then EBREAK
    // Word 0 is LW x1, 0x100(x0) so only reset holds dmem_ren low
    imem[0] = {12'h100, 5'd0, 3'b010, 5'd1, 7'b0000011};
    for (int i = 2; i < 32; i++) begin
      imem[i-1] = init_instr(reg_idx_t'(i));
    end
    for (int i = 31; i < PROG_WORDS - 1; i++) begin
      imem[i] = random_instr(PROG_WORDS - 1 - i);
    end
    imem[PROG_WORDS-1] = EBREAK_WORD;
    reset_dut();
    run_until_halt();
    watch_halt(word_t'(4 * (PROG_WORDS - 1)));
    compare_memory();

    // Program 2 has an unknown opcode at word 5 and stores after it
    // Word 0 is a store so only reset holds dmem_wr.we low
    imem[0] = enc_sw(5'd1, 12'h300);
    for (int i = 1; i < 5; i++) begin
      imem[i] = random_instr(0);
    end
    bad_word = lfsr_bits(25);
    imem[5]  = {bad_word[24:0], 7'b0001011};
    for (int i = 6; i < 256; i++) begin
      imem[i] = enc_sw(reg_idx_t'(i % 31 + 1), 12'(4 * i));
    end
    reset_dut();
    run_until_halt();
    watch_halt(word_t'(20));
    compare_memory();

    $display("Regression passed");
    $finish;
  end

endmodule
